// File: sources.f
common/la_pkg.sv
hw/cmd_decoder.sv
hw/sampler.sv
hw/readback.sv
trigger/trigger_unit.sv
capture/sample_ram.sv
capture/capture_ctrl.sv
hw/la_core.sv
verif/la_core_checker.sv
verif/la_core_tb.sv

// File: verif/la_core_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the logic analyzer core
// clock, reset, transmitter model, word monitor,
// reference upload model and word comparison
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module la_core_tb;

  localparam int DEPTH   = 5;
  localparam int NWORDS  = 1 << DEPTH;      // words per upload
  localparam int TIMEOUT = 5000;            // cycles per wait
  localparam int QUIET   = 40;              // idle window after a test

  logic                           clk_i;
  logic                           reset_i;
  logic [la_pkg::SAMPLE_W-1:0]    input_i;
  logic [la_pkg::OPC_W-1:0]       opc_i;
  logic [la_pkg::SAMPLE_W-1:0]    cmd_i;
  logic                           exec_i;
  logic                           tx_rdy_i;
  logic                           tx_stb_o;
  logic [la_pkg::SAMPLE_W-1:0]    tx_data_o;
  logic                           tx_xon_o;
  logic                           tx_xoff_o;

  logic [31:0] rx_q[$];                     // words seen on the tx port
  logic [31:0] exp_q[$];                    // expected words still to compare
  logic [31:0] exp_w;
  logic [31:0] act_w;
  string       cmp_name = "none";
  int          cmp_idx = 0;
  int          rx_count = 0;
  int          xon_cnt = 0;
  int          xoff_cnt = 0;
  int          mismatches = 0;
  int          timeouts = 0;
  integer      seed = 32'h1b802889;
  int          gap;
  int          gap_cnt = 0;

  la_core #(.DEPTH(DEPTH)) DUT (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .input_i   (input_i),
    .opc_i     (opc_i),
    .cmd_i     (cmd_i),
    .exec_i    (exec_i),
    .tx_rdy_i  (tx_rdy_i),
    .tx_stb_o  (tx_stb_o),
    .tx_data_o (tx_data_o),
    .tx_xon_o  (tx_xon_o),
    .tx_xoff_o (tx_xoff_o)
  );

  always #10 clk_i = ~clk_i;                // period 20

  always @(posedge clk_i) input_i <= input_i + 1'b1;  // probe is a free counter

  // transmitter busy for 0 to 7 cycles after each word
  always @(posedge clk_i) begin
    if (reset_i) begin
      tx_rdy_i <= 1'b1;
      gap_cnt  <= 0;
    end else if (tx_stb_o) begin
      gap = $random(seed) & 7;
      tx_rdy_i <= (gap == 0);
      gap_cnt  <= gap;
    end else if (gap_cnt > 1) begin
      gap_cnt <= gap_cnt - 1;
    end else begin
      gap_cnt  <= 0;
      tx_rdy_i <= 1'b1;
    end
  end

  // monitor
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (tx_stb_o) begin
        rx_q.push_back(tx_data_o);
        rx_count++;
      end
      if (tx_xon_o) xon_cnt++;
      if (tx_xoff_o) xoff_cnt++;
    end
  end

  // compare received words in order once expectations exist
  always @(posedge clk_i) begin
    if (exp_q.size() > 0 && rx_q.size() > 0) begin
      exp_w = exp_q.pop_front();
      act_w = rx_q.pop_front();
      check_eq($sformatf("%s word %0d", cmp_name, cmp_idx), exp_w, act_w);
      cmp_idx++;
    end
  end

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %08h actual %08h", name, exp, act);
      mismatches++;
    end
  endtask

  // newest first with counter samples spaced d+1 apart and the trigger at word p-1
  function automatic logic [31:0] ref_word(input logic [31:0] trig, input int k,
                                           input int d, input int p);
    logic [31:0] step;
    step = (p - 1 - k) * (d + 1);
    return trig + step;
  endfunction

  task automatic send_cmd(input logic [la_pkg::OPC_W-1:0] opc, input logic [31:0] arg);
    @(posedge clk_i);
    opc_i  <= opc;
    cmd_i  <= arg;
    exec_i <= 1'b1;
    @(posedge clk_i);
    exec_i <= 1'b0;                         // single-cycle strobe
  endtask

  task automatic settle();
    repeat (QUIET) @(posedge clk_i);        // lets stray words show up
  endtask

  task automatic wait_rx(input string name, input int n);
    int t;
    t = 0;
    while (rx_q.size() < n && t < TIMEOUT) begin
      @(posedge clk_i);
      t++;
    end
    if (rx_q.size() < n) begin
      $display("timeout in %s: got %0d of %0d words", name, rx_q.size(), n);
      timeouts++;
    end
  endtask

  task automatic wait_compared(input string name);
    int t;
    t = 0;
    while (exp_q.size() > 0 && t < TIMEOUT) begin
      @(posedge clk_i);
      t++;
    end
    if (exp_q.size() > 0) begin
      $display("timeout in %s: %0d words were never compared", name, exp_q.size());
      timeouts++;
    end
  endtask

  task automatic check_upload(input string name, input int d, input int p,
                              input logic [31:0] mask, input logic [31:0] val,
                              input bit with_id, input int start);
    int          n;
    int          k;
    logic [31:0] trig;
    n = with_id ? NWORDS + 1 : NWORDS;
    wait_rx(name, n);
    if (rx_q.size() >= n) begin
      trig = rx_q[p - 1];                   // oldest post-trigger word fired
      if (mask != '0) begin
        check_eq({name, " trigger"}, val & mask, trig & mask);
      end
      cmp_name = name;
      cmp_idx  = 0;
      for (k = 0; k < NWORDS; k++) begin
        exp_q.push_back(ref_word(trig, k, d, p));
      end
      if (with_id) exp_q.push_back(la_pkg::ID_WORD);  // id only after the upload
      wait_compared(name);
    end
    settle();
    check_eq({name, " count"}, n, rx_count - start);
    rx_q.delete();
    exp_q.delete();
  endtask

  task automatic capture_test(input string name, input int d, input int p,
                              input logic [31:0] mask, input logic [31:0] val);
    int start;
    send_cmd(la_pkg::OPC_SET_DIV, d);
    send_cmd(la_pkg::OPC_SET_CNT, p);
    send_cmd(la_pkg::OPC_SET_MASK, mask);
    send_cmd(la_pkg::OPC_SET_VAL, val);
    start = rx_count;
    send_cmd(la_pkg::OPC_ARM, '0);
    check_upload(name, d, p, mask, val, 1'b0, start);
  endtask

  task automatic id_test(input string name);
    int start;
    start = rx_count;
    send_cmd(la_pkg::OPC_ID, '0);
    wait_rx(name, 1);
    cmp_name = name;
    cmp_idx  = 0;
    exp_q.push_back(la_pkg::ID_WORD);
    wait_compared(name);
    settle();
    check_eq({name, " count"}, 1, rx_count - start);
    rx_q.delete();
    exp_q.delete();
  endtask

  task automatic flow_test(input string name, input logic [la_pkg::OPC_W-1:0] opc,
                           input bit is_xon);
    int xon0;
    int xoff0;
    int t;
    xon0  = xon_cnt;
    xoff0 = xoff_cnt;
    t     = 0;
    send_cmd(opc, '0);
    while (xon_cnt == xon0 && xoff_cnt == xoff0 && t < TIMEOUT) begin
      @(posedge clk_i);
      t++;
    end
    if (xon_cnt == xon0 && xoff_cnt == xoff0) begin
      $display("timeout in %s: no flow-control pulse seen", name);
      timeouts++;
    end
    settle();
    check_eq({name, " xon"}, is_xon ? 1 : 0, xon_cnt - xon0);
    check_eq({name, " xoff"}, is_xon ? 0 : 1, xoff_cnt - xoff0);
  endtask

  task automatic priority_test();
    int start;
    send_cmd(la_pkg::OPC_SET_DIV, 0);
    send_cmd(la_pkg::OPC_SET_CNT, 8);
    send_cmd(la_pkg::OPC_SET_MASK, '0);
    send_cmd(la_pkg::OPC_SET_VAL, '0);
    start = rx_count;
    send_cmd(la_pkg::OPC_ARM, '0);
    wait_rx("priority", 1);                 // upload has started
    send_cmd(la_pkg::OPC_ID, '0);
    check_upload("priority", 0, 8, '0, '0, 1'b1, start);
    // non-default config that the soft reset must wipe
    send_cmd(la_pkg::OPC_SET_DIV, 5);
    send_cmd(la_pkg::OPC_SET_MASK, 32'h0000_00ff);
    send_cmd(la_pkg::OPC_SET_VAL, 32'h0000_0077);
    start = rx_count;
    send_cmd(la_pkg::OPC_RESET, '0);
    send_cmd(la_pkg::OPC_ARM, '0);
    check_upload("soft reset", 0, NWORDS, '0, '0, 1'b0, start);
  endtask

  initial begin
    clk_i    = 1'b0;
    reset_i  = 1'b1;
    input_i  = '0;
    opc_i    = '0;
    cmd_i    = '0;
    exec_i   = 1'b0;
    tx_rdy_i = 1'b1;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    id_test("id");
    flow_test("flow xon", la_pkg::OPC_XON, 1'b1);
    flow_test("flow xoff", la_pkg::OPC_XOFF, 1'b0);
    capture_test("immediate", 0, 8, '0, '0);
    capture_test("divisor", 3, 8, '0, '0);
    capture_test("value", 0, 4, 32'h0000_00ff, 32'h0000_005a);
    priority_test();
    $display("summary: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, DUT.i_la_core_checker.fail_cnt);
    if (mismatches == 0 && timeouts == 0 && DUT.i_la_core_checker.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/la_core_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port checker for the logic analyzer core
// tx strobe and flow-control assertions bound to la_core
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module la_core_checker (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            tx_rdy_i,
  input  logic                            tx_stb_i,   // observed tx_stb_o
  input  logic [la_pkg::SAMPLE_W-1:0]     tx_data_i,  // observed tx_data_o
  input  logic                            tx_xon_i,
  input  logic                            tx_xoff_i
);

  int fail_cnt = 0;                         // assertion failures so far

  // strobe only toward a ready transmitter
  a_stb_rdy: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_stb_i |-> tx_rdy_i)
    else begin
      $error("tx strobe while the transmitter is not ready");
      fail_cnt++;
    end

  // a stretched strobe would repeat the same word
  a_stb_one: assert property (@(posedge clk_i) disable iff (reset_i)
    tx_stb_i |=> (!tx_stb_i || (tx_data_i != $past(tx_data_i))))
    else begin
      $error("tx strobe held for more than one cycle");
      fail_cnt++;
    end

  a_flow_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(tx_xon_i && tx_xoff_i))
    else begin
      $error("xon and xoff high together");
      fail_cnt++;
    end

  // outputs quiet right after a reset cycle
  a_reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> (!tx_stb_i && !tx_xon_i && !tx_xoff_i))
    else begin
      $error("tx or flow pulse in the cycle after reset");
      fail_cnt++;
    end

endmodule

bind la_core la_core_checker i_la_core_checker (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .tx_rdy_i   (tx_rdy_i),
  .tx_stb_i   (tx_stb_o),
  .tx_data_i  (tx_data_o),
  .tx_xon_i   (tx_xon_o),
  .tx_xoff_i  (tx_xoff_o)
);

`default_nettype wire

// File: hw/la_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// logic analyzer core, top level
// decoder, sampler, trigger, readback, capture
// controller and sample memory
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module la_core #(
  parameter int DEPTH = 5                   // sample memory holds 2^DEPTH words
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [la_pkg::SAMPLE_W-1:0]     input_i,    // probe bus
  input  logic [la_pkg::OPC_W-1:0]        opc_i,
  input  logic [la_pkg::SAMPLE_W-1:0]     cmd_i,
  input  logic                            exec_i,
  input  logic                            tx_rdy_i,   // transmitter can take a word
  output logic                            tx_stb_o,
  output logic [la_pkg::SAMPLE_W-1:0]     tx_data_o,
  output logic                            tx_xon_o,
  output logic                            tx_xoff_o
);

  la_pkg::cfg_strobe_t          strobe;
  la_pkg::cmd_arg_t             arg;
  la_pkg::tx_word_t             rd_word;
  logic [la_pkg::SAMPLE_W-1:0]  smpl;
  logic                         smpl_stb;
  logic                         fire;
  logic                         accept;
  logic                         taken;
  logic                         we;
  logic [DEPTH-1:0]             addr;
  logic [la_pkg::SAMPLE_W-1:0]  wdata;
  logic [la_pkg::SAMPLE_W-1:0]  rdata;

  cmd_decoder i_cmd_decoder (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .exec_i     (exec_i),
    .opc_i      (opc_i),
    .cmd_i      (cmd_i),
    .strobe_o   (strobe),
    .arg_o      (arg),
    .xon_o      (tx_xon_o),
    .xoff_o     (tx_xoff_o)
  );

  sampler i_sampler (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .strobe_i   (strobe),
    .arg_i      (arg),
    .data_i     (input_i),
    .smpl_o     (smpl),
    .smpl_stb_o (smpl_stb)
  );

  trigger_unit i_trigger_unit (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .strobe_i   (strobe),
    .arg_i      (arg),
    .smpl_i     (smpl),
    .smpl_stb_i (smpl_stb),
    .accept_i   (accept),
    .fire_o     (fire)
  );

  readback i_readback (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .strobe_i   (strobe),
    .taken_i    (taken),
    .word_o     (rd_word)
  );

  capture_ctrl #(.DEPTH(DEPTH)) i_capture_ctrl (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .strobe_i   (strobe),
    .arg_i      (arg),
    .smpl_i     (smpl),
    .smpl_stb_i (smpl_stb),
    .fire_i     (fire),
    .rd_word_i  (rd_word),
    .rdata_i    (rdata),
    .tx_rdy_i   (tx_rdy_i),
    .accept_o   (accept),
    .we_o       (we),
    .addr_o     (addr),
    .wdata_o    (wdata),
    .taken_o    (taken),
    .tx_stb_o   (tx_stb_o),
    .tx_data_o  (tx_data_o)
  );

  sample_ram #(.DEPTH(DEPTH)) i_sample_ram (
    .clk_i      (clk_i),
    .we_i       (we),
    .addr_i     (addr),
    .wdata_i    (wdata),
    .rdata_o    (rdata)
  );

endmodule

`default_nettype wire

// File: capture/capture_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// capture controller
// circular write addressing, fill and post-trigger
// counting, newest-first upload, tx arbitration
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module capture_ctrl #(
  parameter int DEPTH = 5                   // sample memory address width
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  la_pkg::cfg_strobe_t             strobe_i,
  input  la_pkg::cmd_arg_t                arg_i,
  input  logic [la_pkg::SAMPLE_W-1:0]     smpl_i,
  input  logic                            smpl_stb_i,
  input  logic                            fire_i,     // trigger match
  input  la_pkg::tx_word_t                rd_word_i,  // readback word
  input  logic [la_pkg::SAMPLE_W-1:0]     rdata_i,    // memory read data
  input  logic                            tx_rdy_i,
  output logic                            accept_o,   // fire taken, disarms the trigger
  output logic                            we_o,
  output logic [DEPTH-1:0]                addr_o,
  output logic [la_pkg::SAMPLE_W-1:0]     wdata_o,
  output logic                            taken_o,    // readback word sent
  output logic                            tx_stb_o,
  output logic [la_pkg::SAMPLE_W-1:0]     tx_data_o
);

  typedef enum logic [2:0] {ST_IDLE, ST_FILL, ST_ARMED, ST_POST, ST_UPLOAD} state_t;

  localparam logic [DEPTH:0] P_MAX = 1'b1 << DEPTH;  // whole buffer

  state_t           state_q;
  logic [DEPTH-1:0] wptr_q;                 // next write address
  logic [DEPTH-1:0] rptr_q;                 // upload read address
  logic [DEPTH-1:0] fill_q;                 // writes since arm
  logic [DEPTH-1:0] left_q;                 // upload words after the current one
  logic [DEPTH:0]   p_q;                    // post-trigger count p
  logic [DEPTH:0]   post_q;                 // post-trigger writes still to do
  logic             rvalid_q;               // rdata_i belongs to rptr_q
  logic             capturing;
  logic             uploading;
  logic             last_wr;                // final capture write
  logic             smpl_tx;
  logic [15:0]      cnt_arg;

  assign capturing = state_q inside {ST_FILL, ST_ARMED, ST_POST};
  assign uploading = state_q == ST_UPLOAD;
  assign accept_o  = (state_q == ST_ARMED) & fire_i;  // fire comes with a strobe
  assign last_wr   = (accept_o & (p_q == 'd1)) |
                     ((state_q == ST_POST) & smpl_stb_i & (post_q == 'd1));

  assign we_o    = capturing & smpl_stb_i;
  assign addr_o  = uploading ? rptr_q : wptr_q;
  assign wdata_o = smpl_i;

  // samples own the tx path during upload, readback waits
  assign smpl_tx   = uploading & rvalid_q & tx_rdy_i;
  assign taken_o   = ~uploading & rd_word_i.valid & tx_rdy_i;
  assign tx_stb_o  = smpl_tx | taken_o;
  assign tx_data_o = uploading ? rdata_i : rd_word_i.data;

  // p clamped to 1 .. 2^DEPTH
  assign cnt_arg = arg_i.arg[15:0];
  always_ff @(posedge clk_i) begin
    if (reset_i || strobe_i.soft_clear) begin
      p_q <= P_MAX;
    end else if (strobe_i.set_cnt) begin
      if (cnt_arg == '0)              p_q <= 'd1;
      else if (cnt_arg > 16'(P_MAX))  p_q <= P_MAX;
      else                            p_q <= cnt_arg[DEPTH:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= ST_IDLE;
      wptr_q   <= '0;
      rptr_q   <= '0;
      fill_q   <= '0;
      left_q   <= '0;
      post_q   <= '0;
      rvalid_q <= 1'b0;
    end else if (strobe_i.soft_clear) begin
      state_q  <= ST_IDLE;
      rvalid_q <= 1'b0;
    end else if (strobe_i.arm) begin
      state_q  <= ST_FILL;                  // also restarts a running capture
      fill_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      if (we_o) wptr_q <= wptr_q + 1'b1;    // circular
      if (last_wr) begin
        state_q  <= ST_UPLOAD;
        rptr_q   <= wptr_q;                 // newest word first
        left_q   <= '1;
        rvalid_q <= 1'b0;
      end else begin
        case (state_q)
          ST_FILL: begin
            if (smpl_stb_i) begin
              fill_q <= fill_q + 1'b1;
              if (fill_q == '1) state_q <= ST_ARMED;  // buffer full once
            end
          end
          ST_ARMED: begin
            if (accept_o) begin
              post_q  <= p_q - 1'b1;        // triggering sample counts
              state_q <= ST_POST;
            end
          end
          ST_POST: begin
            if (smpl_stb_i) post_q <= post_q - 1'b1;
          end
          ST_UPLOAD: begin
            if (smpl_tx) begin
              rptr_q   <= rptr_q - 1'b1;    // walk backward
              left_q   <= left_q - 1'b1;
              rvalid_q <= 1'b0;             // wait for the new read
              if (left_q == '0) state_q <= ST_IDLE;
            end else begin
              rvalid_q <= 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: capture/sample_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sample memory
// single port, 2^DEPTH words, registered read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module sample_ram #(
  parameter int DEPTH = 5                   // address width
) (
  input  logic                            clk_i,
  input  logic                            we_i,
  input  logic [DEPTH-1:0]                addr_i,
  input  logic [la_pkg::SAMPLE_W-1:0]     wdata_i,
  output logic [la_pkg::SAMPLE_W-1:0]     rdata_o     // one cycle after addr_i
);

  logic [la_pkg::SAMPLE_W-1:0] mem_q [2**DEPTH];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i];               // old data on a write to the same word
  end

endmodule

`default_nettype wire

// File: trigger/trigger_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trigger unit
// mask and value registers, armed flag and
// the single-stage match on each strobed sample
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module trigger_unit (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  la_pkg::cfg_strobe_t             strobe_i,
  input  la_pkg::cmd_arg_t                arg_i,
  input  logic [la_pkg::SAMPLE_W-1:0]     smpl_i,
  input  logic                            smpl_stb_i,
  input  logic                            accept_i,   // controller took the fire
  output logic                            fire_o      // match, aligned with smpl_stb_i
);

  logic [la_pkg::SAMPLE_W-1:0] mask_q;      // bits that take part in the match
  logic [la_pkg::SAMPLE_W-1:0] val_q;       // expected level of those bits
  logic                        armed_q;
  logic                        match;

  always_ff @(posedge clk_i) begin
    if (reset_i || strobe_i.soft_clear) begin
      mask_q <= '0;
      val_q  <= '0;
    end else begin
      if (strobe_i.set_mask) mask_q <= arg_i.arg;
      if (strobe_i.set_val)  val_q  <= arg_i.arg;
    end
  end

  // armed until the controller accepts a fire, arm restarts the search
  always_ff @(posedge clk_i) begin
    if (reset_i || strobe_i.soft_clear) begin
      armed_q <= 1'b0;
    end else if (strobe_i.arm) begin
      armed_q <= 1'b1;
    end else if (accept_i) begin
      armed_q <= 1'b0;
    end
  end

  // zero mask matches every sample
  assign match  = ((smpl_i ^ val_q) & mask_q) == '0;
  assign fire_o = armed_q & smpl_stb_i & match; // may repeat until accepted

endmodule

`default_nettype wire

// File: hw/readback.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// readback unit
// holds the pending id answer until it is sent
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module readback (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  la_pkg::cfg_strobe_t             strobe_i,
  input  logic                            taken_i,    // word accepted by the tx path
  output la_pkg::tx_word_t                word_o      // pending word offered for tx
);

  logic pending_q;                          // one id answer outstanding

  // a new request wins over taken, repeats while pending merge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
    end else if (strobe_i.id_req) begin
      pending_q <= 1'b1;
    end else if (taken_i) begin
      pending_q <= 1'b0;
    end
  end

  assign word_o.valid = pending_q;
  assign word_o.data  = la_pkg::ID_WORD;    // only the id is read back

endmodule

`default_nettype wire

// File: hw/sampler.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sampler
// programmable divider and input sample register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module sampler (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  la_pkg::cfg_strobe_t             strobe_i,
  input  la_pkg::cmd_arg_t                arg_i,
  input  logic [la_pkg::SAMPLE_W-1:0]     data_i,     // probe bus
  output logic [la_pkg::SAMPLE_W-1:0]     smpl_o,     // captured sample
  output logic                            smpl_stb_o  // sample valid, one in every d+1
);

  logic [23:0] div_q;                       // divisor d
  logic [23:0] cnt_q;                       // down-counter, strobe at zero

  always_ff @(posedge clk_i) begin
    if (reset_i || strobe_i.soft_clear) begin
      div_q      <= '0;                     // d = 0, sample every cycle
      cnt_q      <= '0;
      smpl_stb_o <= 1'b0;
    end else if (strobe_i.set_div) begin
      div_q      <= arg_i.arg[23:0];
      cnt_q      <= arg_i.arg[23:0];        // restart the sample phase
      smpl_stb_o <= 1'b0;
    end else if (cnt_q == '0) begin
      cnt_q      <= div_q;                  // reload
      smpl_stb_o <= 1'b1;
    end else begin
      cnt_q      <= cnt_q - 1'b1;
      smpl_stb_o <= 1'b0;
    end
  end

  // sample taken at the edge that raises the strobe
  always_ff @(posedge clk_i) begin
    if (cnt_q == '0) begin
      smpl_o <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/cmd_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command decoder
// turns an opcode strobe into one registered
// configuration strobe or a flow-control pulse
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module cmd_decoder (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            exec_i,     // one-cycle command strobe
  input  logic [la_pkg::OPC_W-1:0]        opc_i,      // opcode, valid with exec_i
  input  logic [la_pkg::SAMPLE_W-1:0]     cmd_i,      // argument, valid with exec_i
  output la_pkg::cfg_strobe_t             strobe_o,   // decoded strobes, one cycle late
  output la_pkg::cmd_arg_t                arg_o,      // argument aligned with strobe_o
  output logic                            xon_o,      // flow control on pulse
  output logic                            xoff_o      // flow control off pulse
);

  // strobes are cleared every cycle and set only by a known opcode
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      strobe_o <= '0;
      xon_o    <= 1'b0;
      xoff_o   <= 1'b0;
    end else begin
      strobe_o <= '0;                       // default, all strobes low
      xon_o    <= 1'b0;
      xoff_o   <= 1'b0;
      if (exec_i) begin
        case (opc_i)
          la_pkg::OPC_RESET:    strobe_o.soft_clear <= 1'b1;
          la_pkg::OPC_ARM:      strobe_o.arm        <= 1'b1;
          la_pkg::OPC_ID:       strobe_o.id_req     <= 1'b1;
          la_pkg::OPC_XON:      xon_o               <= 1'b1;
          la_pkg::OPC_XOFF:     xoff_o              <= 1'b1;
          la_pkg::OPC_SET_DIV:  strobe_o.set_div    <= 1'b1;
          la_pkg::OPC_SET_CNT:  strobe_o.set_cnt    <= 1'b1;
          la_pkg::OPC_SET_MASK: strobe_o.set_mask   <= 1'b1;
          la_pkg::OPC_SET_VAL:  strobe_o.set_val    <= 1'b1;
          default: ;                        // unknown opcode, ignored
        endcase
      end
    end
  end

  // argument is payload, only loaded with a command
  always_ff @(posedge clk_i) begin
    if (exec_i) begin
      arg_o.arg <= cmd_i;
    end
  end

endmodule

`default_nettype wire

// File: common/la_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared definitions of the logic analyzer core
// widths, command opcodes and the id word
// configuration strobe, argument and tx word structs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package la_pkg;

  localparam int SAMPLE_W = 32;             // probe bus and tx word width
  localparam int OPC_W    = 8;              // opcode width

  // short commands, no argument used
  localparam logic [OPC_W-1:0] OPC_RESET    = 8'h00;
  localparam logic [OPC_W-1:0] OPC_ARM      = 8'h01;
  localparam logic [OPC_W-1:0] OPC_ID       = 8'h02;
  localparam logic [OPC_W-1:0] OPC_XON      = 8'h11;
  localparam logic [OPC_W-1:0] OPC_XOFF     = 8'h13;
  // long commands, argument carried on cmd_i
  localparam logic [OPC_W-1:0] OPC_SET_DIV  = 8'h80;  // divisor in arg[23:0]
  localparam logic [OPC_W-1:0] OPC_SET_CNT  = 8'h81;  // post-trigger count in arg[15:0]
  localparam logic [OPC_W-1:0] OPC_SET_MASK = 8'hC0;
  localparam logic [OPC_W-1:0] OPC_SET_VAL  = 8'hC1;

  // ascii "1ALS", the client sees "SLA1" when the low byte goes out first
  localparam logic [SAMPLE_W-1:0] ID_WORD = 32'h3141_4c53;

  // one-cycle configuration strobes, at most one bit high at a time
  typedef struct packed {
    logic soft_clear;                       // back to reset configuration
    logic arm;                              // start a new capture
    logic id_req;                           // client asks for the id word
    logic set_div;                          // load sample divisor
    logic set_cnt;                          // load post-trigger count
    logic set_mask;                         // load trigger mask
    logic set_val;                          // load trigger value
  } cfg_strobe_t;

  // command argument, registered with the strobes
  typedef struct packed {
    logic [SAMPLE_W-1:0] arg;
  } cmd_arg_t;

  // word offered to the transmit path
  typedef struct packed {
    logic                valid;
    logic [SAMPLE_W-1:0] data;
  } tx_word_t;

endpackage

`default_nettype wire
